//--- files.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_capture.sv
verilog/load_align.sv
verilog/data_ram.sv
verilog/mem_writeback.sv
verilog/mem_stage_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_top \
    -f files.f -Mdir obj_dir

out=$(./obj_dir/Vtb_top)
echo "$out"

# exit status follows the search for the pass line
echo "$out" | grep -qx "Result: PASSED"

//--- verif/tb_top.sv
`include "mem_cfg.svh"

`default_nettype none

module tb_top import mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                       CLK;
    logic                       arst_n;
    logic                       stall;
    logic                       flush;
    mem_op_e                    op;
    logic [`MEM_RD_W-1:0]       rd;
    logic [`MEM_DATA_W-1:0]     reg_data;
    logic [`MEM_ADDR_W-1:0]     addr;
    logic [`MEM_DATA_W/8-1:0]   strb;
    logic                       signed_ld;
    logic [`MEM_DATA_W-1:0]     st_data;
    logic                       wb_valid;
    logic [`MEM_RD_W-1:0]       wb_rd;
    logic [`MEM_DATA_W-1:0]     wb_data;
    int                         n_done;
    int                         n_errors;
    int                         n_pending;

    int issued = 0;
    int test_no = 1;
    int done_mark = 0;
    int err_mark = 0;

    // four bytes and the halfwords at lanes 0..2
    logic [3:0] sub_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b0110, 4'b1100};

    mem_stage_top dut_i (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .stall     (stall),
        .flush     (flush),
        .op        (op),
        .rd        (rd),
        .reg_data  (reg_data),
        .addr      (addr),
        .strb      (strb),
        .signed_ld (signed_ld),
        .st_data   (st_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    tb_checker chk_i (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .stall     (stall),
        .flush     (flush),
        .op        (op),
        .rd        (rd),
        .reg_data  (reg_data),
        .addr      (addr),
        .strb      (strb),
        .signed_ld (signed_ld),
        .st_data   (st_data),
        .wr_en     (dut_i.wr_en),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .n_done    (n_done),
        .n_errors  (n_errors),
        .n_pending (n_pending)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic drive_bundle(input mem_op_e o, input logic [`MEM_RD_W-1:0] r,
            input logic [`MEM_DATA_W-1:0] rdat, input logic [`MEM_ADDR_W-1:0] a,
            input logic [`MEM_DATA_W/8-1:0] s, input logic sg,
            input logic [`MEM_DATA_W-1:0] sd, input logic st, input logic fl);
        @(posedge CLK);
        op <= o;
        rd <= r;
        reg_data <= rdat;
        addr <= a;
        strb <= s;
        signed_ld <= sg;
        st_data <= sd;
        stall <= st;
        flush <= fl;
        if (!st && !fl) begin
            issued++;
        end
    endtask

    function automatic logic [`MEM_ADDR_W-1:0] rand_word_addr();
        return `MEM_ADDR_W'($urandom_range(0, (1 << `MEM_DEPTH_LOG2) - 1)) << 2;
    endfunction

    task automatic store_word(input logic [`MEM_ADDR_W-1:0] a,
            input logic [`MEM_DATA_W-1:0] d, input logic [3:0] s);
        drive_bundle(MOP_STORE, '0, '0, a, s, 1'b0, d, 1'b0, 1'b0);
    endtask

    task automatic load_from(input logic [`MEM_ADDR_W-1:0] a, input logic [3:0] s,
            input logic sg);
        drive_bundle(MOP_LOAD, 5'($urandom_range(1, 31)), $urandom(), a, s, sg,
                     $urandom(), 1'b0, 1'b0);
    endtask

    task automatic idle_cycle();
        drive_bundle(MOP_NONE, '0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic park_stalled();
        drive_bundle(MOP_NONE, '0, '0, '0, '0, 1'b0, '0, 1'b1, 1'b0);
    endtask

    // random bundles that are never accepted
    task automatic hold_stall(input int cycles);
        repeat (cycles) begin
            drive_bundle(mem_op_e'(2'($urandom_range(0, 3))), 5'($urandom_range(0, 31)),
                         $urandom(), $urandom(), 4'($urandom_range(0, 15)), 1'b1,
                         $urandom(), 1'b1, 1'b0);
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        idle_cycle();
        waited = 0;
        // hold the stage stalled while the last writebacks are checked
        while (n_done < issued && waited < 64) begin
            park_stalled();
            waited++;
        end
        if (n_done < issued) begin
            $display("timeout: %s never completed its writebacks", name);
            $display("Result: FAILED");
            $finish;
        end else begin
            $display("test %0d %s: %0d writebacks checked, %0d errors", test_no, name,
                     n_done - done_mark, n_errors - err_mark);
            test_no++;
            done_mark = n_done;
            err_mark = n_errors;
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < (1 << `MEM_DEPTH_LOG2); i++) begin
            store_word(32'(i) << 2, 32'(i) * 32'h9e37_79b1 + 32'h0bad_f00d, 4'hf);
        end
    endtask

    task automatic reg_pass_through();
        logic [`MEM_RD_W-1:0] r;
        for (int i = 0; i < 24; i++) begin
            r = (i % 6 == 0) ? '0 : 5'($urandom_range(1, 31));
            drive_bundle(MOP_REG, r, $urandom(), $urandom(), 4'($urandom_range(0, 15)),
                         1'b0, $urandom(), 1'b0, 1'b0);
        end
    endtask

    task automatic store_then_load();
        logic [`MEM_ADDR_W-1:0] a;
        logic [`MEM_DATA_W-1:0] d;
        for (int n = 0; n < 6; n++) begin
            a = rand_word_addr();
            d = $urandom();
            if (n % 2 == 1) begin
                d = d | 32'h8080_8080;
            end
            store_word(a, d, 4'hf);
            idle_cycle();
            for (int k = 0; k < 7; k++) begin
                load_from(a, sub_strb[k], 1'b0);
                load_from(a, sub_strb[k], 1'b1);
            end
            load_from(a, 4'hf, 1'b0);
        end
    endtask

    task automatic masked_stores();
        logic [`MEM_ADDR_W-1:0] a;
        for (int n = 0; n < 8; n++) begin
            a = rand_word_addr();
            store_word(a, $urandom(), 4'hf);
            store_word(a, $urandom(), 4'($urandom_range(1, 14)));
            idle_cycle();
            load_from(a, 4'hf, 1'b0);
        end
    endtask

    task automatic back_to_back();
        logic [`MEM_ADDR_W-1:0] a;
        for (int n = 0; n < 6; n++) begin
            a = rand_word_addr();
            store_word(a, $urandom(), 4'hf);
            // first load sees the old word
            load_from(a, 4'hf, 1'b0);
            load_from(a, 4'hf, 1'b0);
            idle_cycle();
        end
    endtask

    task automatic stall_and_flush();
        logic [`MEM_ADDR_W-1:0] a;
        for (int n = 0; n < 4; n++) begin
            drive_bundle(MOP_REG, 5'($urandom_range(1, 31)), $urandom(), '0, '0, 1'b0,
                         '0, 1'b0, 1'b0);
            hold_stall($urandom_range(2, 6));
            a = rand_word_addr();
            store_word(a, $urandom(), 4'hf);
            hold_stall($urandom_range(2, 6));
            load_from(a, 4'hf, 1'b0);
            load_from(a, sub_strb[$urandom_range(0, 6)], 1'b1);
            hold_stall($urandom_range(2, 6));
            // store under flush must not reach the RAM
            a = rand_word_addr();
            drive_bundle(MOP_STORE, '0, '0, a, 4'hf, 1'b0, $urandom(), 1'b0, 1'b1);
            idle_cycle();
            load_from(a, 4'hf, 1'b0);
            drive_bundle(MOP_REG, 5'd3, $urandom(), '0, '0, 1'b0, '0, 1'b0, 1'b1);
            drive_bundle(MOP_REG, 5'd7, $urandom(), '0, '0, 1'b0, '0, 1'b0, 1'b0);
            drive_bundle(MOP_REG, 5'd9, $urandom(), '0, '0, 1'b0, '0, 1'b1, 1'b1);
        end
    endtask

    task automatic random_mix();
        logic st;
        logic fl;
        for (int i = 0; i < 320; i++) begin
            st = ($urandom_range(0, 4) == 0);
            fl = ($urandom_range(0, 39) == 0);
            drive_bundle(mem_op_e'(2'($urandom_range(0, 3))), 5'($urandom_range(0, 31)),
                         $urandom(), $urandom(), 4'($urandom_range(0, 15)),
                         1'($urandom_range(0, 1)), $urandom(), st, fl);
        end
    endtask

    initial begin
        int waited;
        int total;
        void'($urandom(59174));
        arst_n <= 1'b0;
        // stalled until the first bundle is driven
        stall <= 1'b1;
        flush <= 1'b0;
        op <= MOP_NONE;
        rd <= '0;
        reg_data <= '0;
        addr <= '0;
        strb <= '0;
        signed_ld <= 1'b0;
        st_data <= '0;
        repeat (10) @(posedge CLK);
        arst_n <= 1'b1;

        fill_memory();
        finish_test("memory fill");
        reg_pass_through();
        finish_test("register pass-through");
        store_then_load();
        finish_test("store then load");
        masked_stores();
        finish_test("byte-masked stores");
        back_to_back();
        finish_test("back-to-back collision");
        stall_and_flush();
        finish_test("stall and flush");
        random_mix();
        finish_test("random mix");

        // park stalled so the last expectation drains
        park_stalled();
        waited = 0;
        while (n_pending != 0 && waited < 16) begin
            @(posedge CLK);
            waited++;
        end
        total = n_errors;
        if (n_pending != 0) begin
            $display("%0d expected writebacks were never checked", n_pending);
            total++;
        end
        $display("%0d tests, %0d writebacks checked, %0d errors", test_no - 1, n_done, total);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`include "mem_cfg.svh"

`default_nettype none

module tb_checker import mem_pkg::*; (
    input  wire                       CLK,
    input  wire                       arst_n,
    input  wire                       stall,
    input  wire                       flush,
    input  wire mem_op_e              op,
    input  wire [`MEM_RD_W-1:0]       rd,
    input  wire [`MEM_DATA_W-1:0]     reg_data,
    input  wire [`MEM_ADDR_W-1:0]     addr,
    input  wire [`MEM_DATA_W/8-1:0]   strb,
    input  wire                       signed_ld,
    input  wire [`MEM_DATA_W-1:0]     st_data,
    input  wire                       wr_en,
    input  wire                       wb_valid,
    input  wire [`MEM_RD_W-1:0]       wb_rd,
    input  wire [`MEM_DATA_W-1:0]     wb_data,
    output int                        n_done,
    output int                        n_errors,
    output int                        n_pending
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                    valid;
        logic [`MEM_RD_W-1:0]    rd;
        logic [`MEM_DATA_W-1:0]  data;
    } wb_exp_t;

    logic [`MEM_DATA_W-1:0]      model_mem [1 << `MEM_DEPTH_LOG2];
    wb_exp_t                     exp_q [$];
    wb_exp_t                     shown = '0;
    logic                        st_pend = 1'b0;
    logic [`MEM_DEPTH_LOG2-1:0]  pend_idx;
    logic [`MEM_DATA_W/8-1:0]    pend_strb;
    logic [`MEM_DATA_W-1:0]      pend_data;
    int                          done_cnt = 0;
    int                          err_cnt = 0;

    // lane select and extension straight from the strobe
    function automatic logic [`MEM_DATA_W-1:0] expected_load(
            input logic [`MEM_DATA_W-1:0] word, input logic [3:0] s, input logic sgn);
        load_size_e              size;
        int                      ones;
        int                      low;
        logic [`MEM_DATA_W-1:0]  raw;
        logic [`MEM_DATA_W-1:0]  val;
        ones = $countones(s);
        low = 0;
        for (int i = 3; i >= 0; i--) begin
            if (s[i]) begin
                low = i;
            end
        end
        if (ones == 1) begin
            size = LSZ_BYTE;
        end else if (ones == 2 && s == (4'b0011 << low)) begin
            size = LSZ_HALF;
        end else begin
            size = LSZ_WORD;
            low = 0;
        end
        raw = word >> (8 * low);
        case (size)
            LSZ_BYTE: begin
                val = `MEM_DATA_W'(raw[7:0]);
                if (sgn && raw[7]) begin
                    val = val | ~(`MEM_DATA_W'(8'hff));
                end
            end
            LSZ_HALF: begin
                val = `MEM_DATA_W'(raw[15:0]);
                if (sgn && raw[15]) begin
                    val = val | ~(`MEM_DATA_W'(16'hffff));
                end
            end
            default: val = raw;
        endcase
        return val;
    endfunction

    function automatic wb_exp_t predict_wb();
        wb_exp_t e;
        e = '0;
        if ((op == MOP_REG || op == MOP_LOAD) && rd != '0) begin
            e.valid = 1'b1;
            e.rd = rd;
            if (op == MOP_LOAD) begin
                e.data = expected_load(model_mem[addr[`MEM_DEPTH_LOG2+1:2]], strb, signed_ld);
            end else begin
                e.data = reg_data;
            end
        end
        return e;
    endfunction

    task automatic compare_wb(input wb_exp_t e);
        string got;
        if (wb_valid !== e.valid || wb_data !== e.data || (e.valid && wb_rd !== e.rd)) begin
            got = $sformatf("got valid=%0b rd=%0d data=%08h", wb_valid, wb_rd, wb_data);
            $display("Fail at %0d ns: writeback expected valid=%0b rd=%0d data=%08h, %s",
                     $time, e.valid, e.rd, e.data, got);
            err_cnt++;
        end
    endtask

    always @(posedge CLK) begin
        if (!arst_n) begin
            exp_q.delete();
            shown = '0;
            st_pend = 1'b0;
        end else begin
            if (exp_q.size() > 0) begin
                shown = exp_q.pop_front();
                done_cnt++;
            end
            compare_wb(shown);
            if (wr_en !== st_pend) begin
                $display("Fail at %0d ns: RAM write enable is %0b, model expects %0b",
                         $time, wr_en, st_pend);
                err_cnt++;
            end
            // stall keeps the shown writeback as it is
            if (flush) begin
                shown = '0;
            end else if (!stall) begin
                exp_q.push_back(predict_wb());
            end
            // the RAM reads first so the store lands after the load above
            if (st_pend) begin
                for (int i = 0; i < `MEM_DATA_W / 8; i++) begin
                    if (pend_strb[i]) begin
                        model_mem[pend_idx][8*i +: 8] = pend_data[8*i +: 8];
                    end
                end
            end
            st_pend = !flush && !stall && (op == MOP_STORE);
            pend_idx = addr[`MEM_DEPTH_LOG2+1:2];
            pend_strb = strb;
            pend_data = st_data;
        end
        n_done <= done_cnt;
        n_errors <= err_cnt;
        n_pending <= exp_q.size();
    end

endmodule

`default_nettype wire

//--- verilog/mem_stage_top.sv
`include "mem_cfg.svh"

`default_nettype none

module mem_stage_top import mem_pkg::*; (
    input  wire                          CLK,
    input  wire                          arst_n,
    input  wire                          stall,
    input  wire                          flush,
    input  wire mem_op_e                 op,
    input  wire [`MEM_RD_W-1:0]          rd,
    input  wire [`MEM_DATA_W-1:0]        reg_data,
    input  wire [`MEM_ADDR_W-1:0]        addr,
    input  wire [`MEM_DATA_W/8-1:0]      strb,
    input  wire                          signed_ld,
    input  wire [`MEM_DATA_W-1:0]        st_data,
    output logic                         wb_valid,
    output logic [`MEM_RD_W-1:0]         wb_rd,
    output logic [`MEM_DATA_W-1:0]       wb_data
);

    logic                        rd_en;
    logic [`MEM_ADDR_W-1:0]      rd_addr;
    logic [`MEM_DATA_W-1:0]      rd_data;
    logic                        wr_en;
    logic [`MEM_ADDR_W-1:0]      wr_addr;
    logic [`MEM_DATA_W/8-1:0]    wr_strb;
    logic [`MEM_DATA_W-1:0]      wr_data;
    mem_op_e                     cap_op;
    logic [`MEM_RD_W-1:0]        cap_rd;
    logic [`MEM_DATA_W-1:0]      cap_reg_data;
    logic [`MEM_DATA_W/8-1:0]    cap_strb;
    logic                        cap_signed;
    logic [`MEM_DATA_W-1:0]      ld_value;

    mem_capture capture_i (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .stall        (stall),
        .flush        (flush),
        .op           (op),
        .rd           (rd),
        .reg_data     (reg_data),
        .addr         (addr),
        .strb         (strb),
        .signed_ld    (signed_ld),
        .st_data      (st_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_strb      (wr_strb),
        .wr_data      (wr_data),
        .cap_op       (cap_op),
        .cap_rd       (cap_rd),
        .cap_reg_data (cap_reg_data),
        .cap_strb     (cap_strb),
        .cap_signed   (cap_signed)
    );

    data_ram ram_i (
        .CLK     (CLK),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_strb (wr_strb),
        .wr_data (wr_data)
    );

    // load data and captured fields arrive in the same cycle
    load_align align_i (
        .rd_data   (rd_data),
        .strb      (cap_strb),
        .signed_ld (cap_signed),
        .ld_value  (ld_value)
    );

    mem_writeback wb_i (
        .cap_op       (cap_op),
        .cap_rd       (cap_rd),
        .cap_reg_data (cap_reg_data),
        .ld_value     (ld_value),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

//--- verilog/mem_writeback.sv
`include "mem_cfg.svh"

`default_nettype none

module mem_writeback import mem_pkg::*; (
    input  wire mem_op_e                 cap_op,
    input  wire [`MEM_RD_W-1:0]          cap_rd,
    input  wire [`MEM_DATA_W-1:0]        cap_reg_data,
    input  wire [`MEM_DATA_W-1:0]        ld_value,
    output logic                         wb_valid,
    output logic [`MEM_RD_W-1:0]         wb_rd,
    output logic [`MEM_DATA_W-1:0]       wb_data
);

    logic writes_reg;
    logic is_load;

    assign is_load    = (cap_op == MOP_LOAD);
    assign writes_reg = (cap_op == MOP_REG) || is_load;

    // x0 is hardwired and never written
    assign wb_valid = writes_reg && (cap_rd != '0);
    assign wb_rd    = cap_rd;

    always_comb begin
        if (!wb_valid) begin
            wb_data = '0;
        end else if (is_load) begin
            wb_data = ld_value;
        end else begin
            wb_data = cap_reg_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`include "mem_cfg.svh"

`default_nettype none

module data_ram (
    input  wire                          CLK,
    input  wire                          rd_en,
    input  wire [`MEM_ADDR_W-1:0]        rd_addr,
    output logic [`MEM_DATA_W-1:0]       rd_data,
    input  wire                          wr_en,
    input  wire [`MEM_ADDR_W-1:0]        wr_addr,
    input  wire [`MEM_DATA_W/8-1:0]      wr_strb,
    input  wire [`MEM_DATA_W-1:0]        wr_data
);

    localparam int DEPTH  = 1 << `MEM_DEPTH_LOG2;
    localparam int STRB_W = `MEM_DATA_W / 8;

    logic [`MEM_DATA_W-1:0]     mem [DEPTH];
    logic [`MEM_DEPTH_LOG2-1:0] rd_idx;
    logic [`MEM_DEPTH_LOG2-1:0] wr_idx;

    // word index with the byte offset bits dropped
    assign rd_idx = rd_addr[`MEM_DEPTH_LOG2+1:2];
    assign wr_idx = wr_addr[`MEM_DEPTH_LOG2+1:2];

    // a same-edge write is not seen by this read
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/load_align.sv
`include "mem_cfg.svh"

`default_nettype none

module load_align import mem_pkg::*; (
    input  wire [`MEM_DATA_W-1:0]    rd_data,
    input  wire [`MEM_DATA_W/8-1:0]  strb,
    input  wire                      signed_ld,
    output logic [`MEM_DATA_W-1:0]   ld_value
);

    localparam int W = `MEM_DATA_W;

    load_size_e      size;
    logic [1:0]      lane;
    logic [W-1:0]    shifted;

    // strobe -> width and starting byte lane
    always_comb begin
        case (strb)
            4'b0001: begin size = LSZ_BYTE; lane = 2'd0; end
            4'b0010: begin size = LSZ_BYTE; lane = 2'd1; end
            4'b0100: begin size = LSZ_BYTE; lane = 2'd2; end
            4'b1000: begin size = LSZ_BYTE; lane = 2'd3; end
            4'b0011: begin size = LSZ_HALF; lane = 2'd0; end
            4'b0110: begin size = LSZ_HALF; lane = 2'd1; end
            4'b1100: begin size = LSZ_HALF; lane = 2'd2; end
            // odd strobes fall back to a full word
            default: begin size = LSZ_WORD; lane = 2'd0; end
        endcase
    end

    // bring the selected lane down to bit 0
    assign shifted = rd_data >> {lane, 3'b000};

    always_comb begin
        case (size)
            LSZ_BYTE: begin
                ld_value = {{(W - 8){signed_ld & shifted[7]}}, shifted[7:0]};
            end
            LSZ_HALF: begin
                ld_value = {{(W - 16){signed_ld & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                ld_value = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mem_capture.sv
`include "mem_cfg.svh"

`default_nettype none

module mem_capture import mem_pkg::*; (
    input  wire                          CLK,
    input  wire                          arst_n,
    input  wire                          stall,
    input  wire                          flush,
    input  wire mem_op_e                 op,
    input  wire [`MEM_RD_W-1:0]          rd,
    input  wire [`MEM_DATA_W-1:0]        reg_data,
    input  wire [`MEM_ADDR_W-1:0]        addr,
    input  wire [`MEM_DATA_W/8-1:0]      strb,
    input  wire                          signed_ld,
    input  wire [`MEM_DATA_W-1:0]        st_data,
    output logic                         rd_en,
    output logic [`MEM_ADDR_W-1:0]       rd_addr,
    output logic                         wr_en,
    output logic [`MEM_ADDR_W-1:0]       wr_addr,
    output logic [`MEM_DATA_W/8-1:0]     wr_strb,
    output logic [`MEM_DATA_W-1:0]       wr_data,
    output mem_op_e                      cap_op,
    output logic [`MEM_RD_W-1:0]         cap_rd,
    output logic [`MEM_DATA_W-1:0]       cap_reg_data,
    output logic [`MEM_DATA_W/8-1:0]     cap_strb,
    output logic                         cap_signed
);

    logic                    accept;
    logic                    st_pend;
    logic [`MEM_ADDR_W-1:0]  cap_addr;
    logic [`MEM_DATA_W-1:0]  cap_st_data;

    assign accept = !stall && !flush;

    // read goes out with the bundle so data lines up with the capture
    assign rd_en   = (op == MOP_LOAD) && !stall;
    assign rd_addr = addr;

    // flush beats stall; a stalled store still writes on its first edge only
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cap_op  <= MOP_NONE;
            st_pend <= 1'b0;
        end else if (flush) begin
            cap_op  <= MOP_NONE;
            st_pend <= 1'b0;
        end else if (stall) begin
            st_pend <= 1'b0;
        end else begin
            cap_op  <= op;
            st_pend <= (op == MOP_STORE);
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            cap_rd       <= rd;
            cap_reg_data <= reg_data;
            cap_addr     <= addr;
            cap_strb     <= strb;
            cap_signed   <= signed_ld;
            cap_st_data  <= st_data;
        end
    end

    assign wr_en   = st_pend;
    assign wr_addr = cap_addr;
    assign wr_strb = cap_strb;
    assign wr_data = cap_st_data;

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // what the bundle asks of the memory stage
    typedef enum logic [1:0] {
        MOP_NONE  = 2'd0,
        MOP_REG   = 2'd1,
        MOP_LOAD  = 2'd2,
        MOP_STORE = 2'd3
    } mem_op_e;

    // load width, decoded from the byte strobe
    typedef enum logic [1:0] {
        LSZ_BYTE = 2'd0,
        LSZ_HALF = 2'd1,
        LSZ_WORD = 2'd2
    } load_size_e;

endpackage

`default_nettype wire

//--- verilog/mem_cfg.svh
`default_nettype none

`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// one word and the register width
`define MEM_DATA_W 32

// byte address
`define MEM_ADDR_W 32

// register index for x0..x31
`define MEM_RD_W 5

// 256 words of data RAM
`define MEM_DEPTH_LOG2 8

`endif

`default_nettype wire
